/* i2c_master_ctrl.f */
src/i2c_bus_pkg.sv
src/i2c_fsm_pkg.sv
src/i2c_scl_tracker.sv
src/i2c_ack_tracker.sv
src/i2c_master_fsm.sv
src/i2c_master_top.sv
test/i2c_master_tb.sv

/* Makefile */
TOP := i2c_master_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f i2c_master_ctrl.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* test/i2c_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_tb;

    import i2c_bus_pkg::*;
    import i2c_fsm_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TRANS  = 200;
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_HALF   = 11;        // Longest SCL half-period in core cycles
    localparam int FRAME_CYCLES = (FRAME_BITS + 1) * 2 * MAX_HALF;
    localparam int TRANS_FRAMES = 12;      // Address, data bytes and restarts with margin
    localparam longint WATCHDOG_NS =
        longint'(NUM_TRANS) * TRANS_FRAMES * FRAME_CYCLES * CLK_PERIOD;

    logic     clk, reset_n;
    logic     enable, repeat_start, rw, full, empty, sda, scl;
    logic     w_fifo_en, r_fifo_en, sda_low_en, clk_en, sda_en, scl_en;
    logic     write_data_en, write_addr_en, receive_data_en;
    bit_idx_t count_bit;

    // Reference model registers and helpers
    ctrl_state_t m_state, m_next;
    logic        m_scl_q, m_rise, m_fall, m_done, m_in_byte;
    logic [3:0]  m_rise_cnt;
    bit_idx_t    m_bit;
    logic        m_go_read, m_go_write, m_r_pop, m_w_push;
    int          trans_done, restarts, addr_stops, pops, pushes;

    logic [31:0] seed;
    int          half_cnt, tx_level, rx_level;

    i2c_master_top UUT (
        .i2c_core_clk_i    (clk),
        .reset_ni          (reset_n),
        .enable_i          (enable),
        .repeat_start_i    (repeat_start),
        .rw_i              (rw),
        .full_i            (full),
        .empty_i           (empty),
        .i2c_sda_i         (sda),
        .i2c_scl_i         (scl),
        .w_fifo_en_o       (w_fifo_en),
        .r_fifo_en_o       (r_fifo_en),
        .sda_low_en_o      (sda_low_en),
        .clk_en_o          (clk_en),
        .write_data_en_o   (write_data_en),
        .write_addr_en_o   (write_addr_en),
        .receive_data_en_o (receive_data_en),
        .count_bit_o       (count_bit),
        .i2c_sda_en_o      (sda_en),
        .i2c_scl_en_o      (scl_en)
    );

    // Upper LCG bits, the low ones repeat too quickly
    function automatic int random_below(input int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[31:16]) % n;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // --------------------
    // Stimulus: SCL generator, slave, FIFO and control

    initial begin
        seed = 32'h800c_d739;
        {reset_n, enable, repeat_start, rw, full} = '0;
        {empty, sda, scl} = 3'b111;
        half_cnt = 0;
        tx_level = 0;
        rx_level = 0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (!clk_en) begin
                scl      = 1'b1;   // Bus idle
                half_cnt = 3 + random_below(8);
            end else if (half_cnt == 0) begin
                scl      = ~scl;
                half_cnt = 3 + random_below(8);
            end else begin
                half_cnt = half_cnt - 1;
            end
            if (sda_en) begin
                sda = sda_low_en ? 1'b0 : (random_below(2) == 1);
            end else begin
                sda = (random_below(4) == 0);  // Slave ACKs three times in four
            end
            if (r_fifo_en && tx_level > 0) tx_level--;
            if (w_fifo_en && rx_level < FIFO_DEPTH) rx_level++;
            enable = 1'b0;
            if (!clk_en && random_below(4) == 0) begin
                enable   = 1'b1;
                rw       = (random_below(2) == 1);
                tx_level = random_below(FIFO_DEPTH + 1);
                rx_level = random_below(FIFO_DEPTH + 1);
            end
            repeat_start = (random_below(8) == 0);
            empty        = (tx_level == 0);
            full         = (rx_level == FIFO_DEPTH);
        end
    end

    // --------------------
    // Reference model, checked mid-cycle while inputs are stable

    always @(negedge clk) begin
        if (!reset_n) begin
            m_state    = IDLE;
            m_scl_q    = 1'b1;
            m_rise_cnt = '0;
            m_bit      = BIT_IDX_MSB;
            {m_go_read, m_go_write, m_r_pop, m_w_push} = '0;
        end
        m_rise = scl & ~m_scl_q;
        m_fall = ~scl & m_scl_q;
        m_done = (m_rise_cnt == FRAME_BITS) && m_fall;

        compare_value(UUT.state, m_state, "controller state");
        compare_value(clk_en, m_state != IDLE, "clk_en_o");
        compare_value(scl_en, m_state != IDLE, "i2c_scl_en_o");
        compare_value(sda_low_en, (m_state inside {START, READ_LATER_ACK, WRITE_ACK}) ||
                      (m_state == STOP && sda), "sda_low_en_o");
        compare_value(write_addr_en, m_state == ADDRESS && !scl, "write_addr_en_o");
        compare_value(write_data_en, m_state == WRITE_DATA && !scl, "write_data_en_o");
        compare_value(receive_data_en, m_state == READ_DATA && scl, "receive_data_en_o");
        compare_value(sda_en, m_state inside {START, ADDRESS, WRITE_DATA, WRITE_ACK, STOP},
                      "i2c_sda_en_o");
        compare_value(count_bit, m_bit, "count_bit_o");
        compare_value(r_fifo_en, m_r_pop, "r_fifo_en_o");
        compare_value(w_fifo_en, m_w_push, "w_fifo_en_o");

        m_next = m_state;
        case (m_state)
            IDLE:         m_next = enable ? START : IDLE;
            START:        m_next = !scl ? ADDRESS : START;
            ADDRESS:      m_next = m_done ? READ_ACK : ADDRESS;
            READ_ACK:     if (m_fall) m_next = m_go_read ? READ_DATA :
                                               (m_go_write ? WRITE_DATA : STOP);
            WRITE_DATA:   m_next = m_done ? READ_LATER_ACK : WRITE_DATA;
            READ_LATER_ACK: begin
                if (m_fall) m_next = (empty || (!m_go_write && !repeat_start)) ? STOP :
                                     (!m_go_write ? REPEAT_START : WRITE_DATA);
            end
            READ_DATA:    m_next = m_done ? WRITE_ACK : READ_DATA;
            WRITE_ACK:    if (m_fall) m_next = repeat_start ? REPEAT_START :
                                               (!full ? READ_DATA : STOP);
            REPEAT_START: m_next = m_rise ? START : REPEAT_START;
            STOP:         m_next = m_rise ? IDLE : STOP;
            default:      m_next = IDLE;
        endcase

        if (reset_n) begin
            if (m_state == STOP && m_next == IDLE) trans_done++;
            if (m_state == REPEAT_START && m_next == START) restarts++;
            if (m_state == READ_ACK && m_next == STOP) addr_stops++;
            m_r_pop  = (m_state == READ_LATER_ACK) && m_rise;
            m_w_push = (m_state == WRITE_ACK) && m_rise;
            pops   += int'(m_r_pop);
            pushes += int'(m_w_push);
            if (!(m_state inside {READ_ACK, READ_LATER_ACK})) begin
                {m_go_read, m_go_write} = 2'b00;
            end else if (m_rise && !sda && rw && !full) begin
                {m_go_read, m_go_write} = 2'b10;
            end else if (m_rise && !sda && !rw && !empty) begin
                {m_go_read, m_go_write} = 2'b01;
            end
            m_in_byte  = m_state inside {ADDRESS, WRITE_DATA, READ_DATA};
            m_rise_cnt = m_in_byte ? m_rise_cnt + 4'(m_rise) : 4'd0;
            if (!m_in_byte) begin
                m_bit = BIT_IDX_MSB;
            end else if (m_bit != 0 && ((m_state == READ_DATA) ? m_fall : m_rise)) begin
                m_bit = m_bit - 1'b1;   // Read side steps on the fall
            end
            m_scl_q = scl;
            m_state = m_next;
        end
    end

    // --------------------
    // End of run and watchdog

    initial begin
        {trans_done, restarts, addr_stops, pops, pushes} = '0;
        wait (trans_done >= NUM_TRANS);
        repeat (4) @(posedge clk);
        compare_value(restarts != 0, 1, "repeated START reached");
        compare_value(addr_stops != 0, 1, "STOP after the address ACK slot reached");
        compare_value(pops != 0, 1, "transmit FIFO read strobe seen");
        compare_value(pushes != 0, 1, "receive FIFO write strobe seen");
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run hung, %0d of %0d transactions finished",
                 trans_done, NUM_TRANS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule : i2c_master_tb

`default_nettype wire

/* src/i2c_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
    input  wire                   i2c_core_clk_i,
    input  wire                   reset_ni,
    input  wire                   enable_i,
    input  wire                   repeat_start_i,
    input  wire                   rw_i,
    input  wire                   full_i,
    input  wire                   empty_i,
    input  wire                   i2c_sda_i,
    input  wire                   i2c_scl_i,
    output logic                  w_fifo_en_o,
    output logic                  r_fifo_en_o,
    output logic                  sda_low_en_o,
    output logic                  clk_en_o,
    output logic                  write_data_en_o,
    output logic                  write_addr_en_o,
    output logic                  receive_data_en_o,
    output i2c_bus_pkg::bit_idx_t count_bit_o,
    output logic                  i2c_sda_en_o,
    output logic                  i2c_scl_en_o
);

    import i2c_fsm_pkg::*;

    // --------------------
    // Internal wiring

    ctrl_state_t state;
    logic        scl_rise;
    logic        scl_fall;
    logic        byte_done;
    logic        go_read;
    logic        go_write;

    i2c_scl_tracker u_scl_tracker (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .i2c_scl_i      (i2c_scl_i),
        .state_i        (state),
        .scl_rise_o     (scl_rise),
        .scl_fall_o     (scl_fall),
        .byte_done_o    (byte_done),
        .count_bit_o    (count_bit_o)
    );

    i2c_ack_tracker u_ack_tracker (
        .i2c_core_clk_i (i2c_core_clk_i),
        .reset_ni       (reset_ni),
        .state_i        (state),
        .scl_rise_i     (scl_rise),
        .i2c_sda_i      (i2c_sda_i),
        .rw_i           (rw_i),
        .full_i         (full_i),
        .empty_i        (empty_i),
        .go_read_o      (go_read),
        .go_write_o     (go_write),
        .r_fifo_en_o    (r_fifo_en_o),
        .w_fifo_en_o    (w_fifo_en_o)
    );

    i2c_master_fsm u_master_fsm (
        .i2c_core_clk_i    (i2c_core_clk_i),
        .reset_ni          (reset_ni),
        .enable_i          (enable_i),
        .repeat_start_i    (repeat_start_i),
        .full_i            (full_i),
        .empty_i           (empty_i),
        .i2c_sda_i         (i2c_sda_i),
        .i2c_scl_i         (i2c_scl_i),
        .scl_rise_i        (scl_rise),
        .scl_fall_i        (scl_fall),
        .byte_done_i       (byte_done),
        .go_read_i         (go_read),
        .go_write_i        (go_write),
        .state_o           (state),
        .clk_en_o          (clk_en_o),
        .sda_low_en_o      (sda_low_en_o),
        .write_addr_en_o   (write_addr_en_o),
        .write_data_en_o   (write_data_en_o),
        .receive_data_en_o (receive_data_en_o),
        .i2c_sda_en_o      (i2c_sda_en_o),
        .i2c_scl_en_o      (i2c_scl_en_o)
    );

endmodule : i2c_master_top

`default_nettype wire

/* src/i2c_master_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_fsm (
    input  wire                      i2c_core_clk_i,
    input  wire                      reset_ni,
    input  wire                      enable_i,          // Start a transaction
    input  wire                      repeat_start_i,
    input  wire                      full_i,
    input  wire                      empty_i,
    input  wire                      i2c_sda_i,
    input  wire                      i2c_scl_i,
    input  wire                      scl_rise_i,
    input  wire                      scl_fall_i,
    input  wire                      byte_done_i,
    input  wire                      go_read_i,
    input  wire                      go_write_i,
    output i2c_fsm_pkg::ctrl_state_t state_o,
    output logic                     clk_en_o,          // Run the SCL generator
    output logic                     sda_low_en_o,      // Pull SDA low
    output logic                     write_addr_en_o,   // Drive address bit on SDA
    output logic                     write_data_en_o,   // Drive data bit on SDA
    output logic                     receive_data_en_o, // Sample SDA into shift reg
    output logic                     i2c_sda_en_o,      // Master owns SDA
    output logic                     i2c_scl_en_o       // Master owns SCL
);

    import i2c_fsm_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // --------------------
    // State register

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next-state logic

    always_comb begin
        state_d = state_q;  // Stay unless a condition below fires

        case (state_q)
            IDLE: begin
                if (enable_i) begin
                    state_d = START;
                end
            end

            START: begin
                // SDA already low, wait for SCL low before the first bit
                if (!i2c_scl_i) begin
                    state_d = ADDRESS;
                end
            end

            ADDRESS: begin
                if (byte_done_i) begin
                    state_d = READ_ACK;
                end
            end

            READ_ACK: begin
                if (scl_fall_i) begin
                    if (go_read_i) begin
                        state_d = READ_DATA;
                    end else if (go_write_i) begin
                        state_d = WRITE_DATA;
                    end else begin
                        state_d = STOP;  // Address NACK or no FIFO room
                    end
                end
            end

            WRITE_DATA: begin
                if (byte_done_i) begin
                    state_d = READ_LATER_ACK;
                end
            end

            READ_LATER_ACK: begin
                if (scl_fall_i) begin
                    if (empty_i || (!go_write_i && !repeat_start_i)) begin
                        state_d = STOP;
                    end else if (!go_write_i) begin
                        state_d = REPEAT_START;  // NACK with a restart pending
                    end else begin
                        state_d = WRITE_DATA;
                    end
                end
            end

            READ_DATA: begin
                if (byte_done_i) begin
                    state_d = WRITE_ACK;
                end
            end

            WRITE_ACK: begin
                if (scl_fall_i) begin
                    if (repeat_start_i) begin
                        state_d = REPEAT_START;
                    end else if (!full_i) begin
                        state_d = READ_DATA;
                    end else begin
                        state_d = STOP;
                    end
                end
            end

            REPEAT_START: begin
                // SDA released, restart once SCL is high again
                if (scl_rise_i) begin
                    state_d = START;
                end
            end

            STOP: begin
                if (scl_rise_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // --------------------
    // Datapath enables

    always_comb begin
        clk_en_o          = (state_q != IDLE);
        i2c_scl_en_o      = (state_q != IDLE);
        sda_low_en_o      = 1'b0;
        write_addr_en_o   = 1'b0;
        write_data_en_o   = 1'b0;
        receive_data_en_o = 1'b0;
        i2c_sda_en_o      = 1'b0;

        case (state_q)
            START: begin
                sda_low_en_o = 1'b1;   // SDA falls while SCL high
                i2c_sda_en_o = 1'b1;
            end
            ADDRESS: begin
                write_addr_en_o = !i2c_scl_i;  // Change SDA only while SCL low
                i2c_sda_en_o    = 1'b1;
            end
            WRITE_DATA: begin
                write_data_en_o = !i2c_scl_i;
                i2c_sda_en_o    = 1'b1;
            end
            READ_LATER_ACK: begin
                sda_low_en_o = 1'b1;
            end
            READ_DATA: begin
                receive_data_en_o = i2c_scl_i;  // Data is stable while SCL high
            end
            WRITE_ACK: begin
                sda_low_en_o = 1'b1;   // Master ACK
                i2c_sda_en_o = 1'b1;
            end
            STOP: begin
                // Hold SDA low until the release gives the STOP edge
                sda_low_en_o = i2c_sda_i;
                i2c_sda_en_o = 1'b1;
            end
            default: begin
                // IDLE, READ_ACK and REPEAT_START leave SDA to the bus
            end
        endcase
    end

    assign state_o = state_q;

endmodule : i2c_master_fsm

`default_nettype wire

/* src/i2c_ack_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_ack_tracker (
    input  wire                      i2c_core_clk_i,
    input  wire                      reset_ni,
    input  i2c_fsm_pkg::ctrl_state_t state_i,
    input  wire                      scl_rise_i,
    input  wire                      i2c_sda_i,     // Low here means ACK
    input  wire                      rw_i,          // 1 read, 0 write
    input  wire                      full_i,        // Receive FIFO full
    input  wire                      empty_i,       // Transmit FIFO empty
    output logic                     go_read_o,
    output logic                     go_write_o,
    output logic                     r_fifo_en_o,   // Pop next byte from transmit FIFO
    output logic                     w_fifo_en_o    // Push received byte to receive FIFO
);

    import i2c_fsm_pkg::*;

    logic in_ack_state;
    logic ack_seen;     // Slave pulled SDA low at the sampling edge
    logic go_read_q;
    logic go_write_q;
    logic r_fifo_en_q;
    logic w_fifo_en_q;

    assign in_ack_state = (state_i == READ_ACK) || (state_i == READ_LATER_ACK);
    assign ack_seen     = scl_rise_i && !i2c_sda_i;

    // --------------------
    // Continue decisions

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            go_read_q  <= 1'b0;
            go_write_q <= 1'b0;
        end else if (!in_ack_state) begin
            go_read_q  <= 1'b0;
            go_write_q <= 1'b0;
        end else if (ack_seen && rw_i && !full_i) begin
            go_read_q  <= 1'b1;
            go_write_q <= 1'b0;
        end else if (ack_seen && !rw_i && !empty_i) begin
            go_read_q  <= 1'b0;
            go_write_q <= 1'b1;
        end
        // NACK or no room, flags hold and the FSM falls through to STOP
    end

    // --------------------
    // FIFO strobes

    // The first byte is already at the transmit FIFO head, so the address
    // ACK pops nothing
    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            r_fifo_en_q <= 1'b0;
            w_fifo_en_q <= 1'b0;
        end else begin
            r_fifo_en_q <= (state_i == READ_LATER_ACK) && scl_rise_i;
            w_fifo_en_q <= (state_i == WRITE_ACK) && scl_rise_i;
        end
    end

    assign go_read_o   = go_read_q;
    assign go_write_o  = go_write_q;
    assign r_fifo_en_o = r_fifo_en_q;
    assign w_fifo_en_o = w_fifo_en_q;

endmodule : i2c_ack_tracker

`default_nettype wire

/* src/i2c_scl_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_scl_tracker (
    input  wire                      i2c_core_clk_i,
    input  wire                      reset_ni,
    input  wire                      i2c_scl_i,     // SCL as seen on the bus
    input  i2c_fsm_pkg::ctrl_state_t state_i,
    output logic                     scl_rise_o,
    output logic                     scl_fall_o,
    output logic                     byte_done_o,   // 8 bits clocked and SCL back low
    output i2c_bus_pkg::bit_idx_t    count_bit_o
);

    import i2c_bus_pkg::*;
    import i2c_fsm_pkg::*;

    logic      scl_q;        // SCL from the previous core cycle
    logic      scl_rise;
    logic      scl_fall;
    logic      in_byte_state;
    rise_cnt_t rise_cnt_q;
    bit_idx_t  count_bit_q;

    // --------------------
    // SCL edge detection

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            scl_q <= 1'b1;  // Bus idles high
        end else begin
            scl_q <= i2c_scl_i;
        end
    end

    assign scl_rise = i2c_scl_i & ~scl_q;
    assign scl_fall = ~i2c_scl_i & scl_q;

    // --------------------
    // Rise counter per byte phase

    assign in_byte_state = (state_i == ADDRESS) || (state_i == WRITE_DATA) ||
                           (state_i == READ_DATA);

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rise_cnt_q <= '0;
        end else if (!in_byte_state) begin
            rise_cnt_q <= '0;  // Restart for the next byte
        end else if (scl_rise) begin
            rise_cnt_q <= rise_cnt_q + 1'b1;
        end
    end

    // Byte ends on the SCL fall after the eighth rise, ready for the ACK slot
    assign byte_done_o = (rise_cnt_q == rise_cnt_t'(FRAME_BITS)) && scl_fall;

    // --------------------
    // Datapath bit index

    always_ff @(posedge i2c_core_clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            count_bit_q <= BIT_IDX_MSB;
        end else if ((state_i == ADDRESS) || (state_i == WRITE_DATA)) begin
            // Transmit side moves on once the slave has sampled the bit
            if (scl_rise && (count_bit_q != '0)) begin
                count_bit_q <= count_bit_q - 1'b1;
            end
        end else if (state_i == READ_DATA) begin
            // Receive side moves on after the bit was captured on high SCL
            if (scl_fall && (count_bit_q != '0)) begin
                count_bit_q <= count_bit_q - 1'b1;
            end
        end else begin
            count_bit_q <= BIT_IDX_MSB;
        end
    end

    assign scl_rise_o  = scl_rise;
    assign scl_fall_o  = scl_fall;
    assign count_bit_o = count_bit_q;

endmodule : i2c_scl_tracker

`default_nettype wire

/* src/i2c_fsm_pkg.sv */
`default_nettype none

package i2c_fsm_pkg;

    // Controller state encodings
    typedef enum logic [3:0] {
        IDLE           = 4'b0000,
        START          = 4'b0001,
        ADDRESS        = 4'b0010,
        READ_ACK       = 4'b0011,   // ACK from slave after the address
        WRITE_DATA     = 4'b0100,
        READ_LATER_ACK = 4'b0101,   // ACK from slave after a data byte
        READ_DATA      = 4'b0110,
        WRITE_ACK      = 4'b0111,   // Master ACK after a received byte
        REPEAT_START   = 4'b1000,
        STOP           = 4'b1001
    } ctrl_state_t;

endpackage : i2c_fsm_pkg

`default_nettype wire

/* src/i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    // --------------------
    // Bus-level widths

    typedef logic [3:0] bit_idx_t;   // Datapath bit index, counts 7 down to 0
    typedef logic [3:0] rise_cnt_t;  // SCL rises seen within one byte phase

    // --------------------
    // Frame constants

    // Address or data bits in one byte, the ACK slot is not counted
    localparam int unsigned FRAME_BITS = 8;

    // First bit on the wire is the MSB
    localparam bit_idx_t BIT_IDX_MSB = 4'd7;

endpackage : i2c_bus_pkg

`default_nettype wire
